/* compile.f */
common/mmrx_pkg.sv
buffer/box_buffer.sv
buffer/buffer_array.sv
mmrx/frame_parser.sv
mmrx/status_router.sv
mmrx/write_ctrl.sv
mmrx/mmrx_top.sv
tb/tb_mmrx.sv

/* Makefile */
# Verilator build and run of the receive memory manager testbench
TOP := tb_mmrx

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

/* tb/tb_mmrx.sv */
`timescale 1ns/1ps
// receive memory manager testbench
// drives random link frames and checks the status outputs and box read-back
// against a reference model of the frame rules
module tb_mmrx;
    import mmrx_pkg::*;

    localparam int SLOT_WORDS = 64;
    localparam int OFS_W      = $clog2(SLOT_WORDS);
    localparam int NUM_FRAMES = 200;
    // budget per frame including the reader delay
    localparam int MAX_CYCLES = NUM_FRAMES * 60;

    logic                 clk_100m;
    logic                 rst_100m;
    chn_type_e            chn_type;
    logic                 slink_empty;
    logic                 slink_dval;
    link_word_t           slink_data;
    logic                 slink_rdreq;
    logic                 rd_sel;
    logic [RD_PORT_W-1:0] rd_port;
    logic [OFS_W-1:0]     rd_addr;
    logic                 rd_dval;
    link_word_t           rd_data;
    logic [NUM_BOXES-1:0] rd_dmm_empty;
    logic [NUM_STA-1:0]   sta_dval;
    link_word_t           sta_data;

    // link FIFO contents with one entry per word
    link_word_t link_q[$];
    chn_type_e  chn_q[$];
    // target box on the end word of a data frame and -1 elsewhere
    int         end_box_q[$];

    // reference model
    link_word_t        sta_exp_q[NUM_STA][$];
    link_word_t        box_exp_q[NUM_BOXES][$];
    logic [SLOT_W-1:0] slot_exp_q[NUM_BOXES][$];

    int         fall_cnt[NUM_BOXES];
    int         cycle_cnt = 0;
    logic [1:0] sel_hist  = '0;
    // reader is between taking a frame off the model and its last check
    bit         read_busy = 1'b0;

    mmrx_top #(
        .SLOT_WORDS (SLOT_WORDS)
    ) u_dut (
        .clk_100m     (clk_100m),
        .rst_100m     (rst_100m),
        .chn_type     (chn_type),
        .slink_empty  (slink_empty),
        .slink_dval   (slink_dval),
        .slink_data   (slink_data),
        .slink_rdreq  (slink_rdreq),
        .rd_sel       (rd_sel),
        .rd_port      (rd_port),
        .rd_addr      (rd_addr),
        .rd_dval      (rd_dval),
        .rd_data      (rd_data),
        .rd_dmm_empty (rd_dmm_empty),
        .sta_dval     (sta_dval),
        .sta_data     (sta_data)
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    // ------------------------------------------------------------------------
    // error stop and value checks
    // ------------------------------------------------------------------------
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            stop_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    always @(posedge clk_100m) begin
        cycle_cnt = cycle_cnt + 1;
        assert (cycle_cnt < MAX_CYCLES) else
            stop_run("timeout: frames were not all delivered and read back in time");
    end

    // ------------------------------------------------------------------------
    // frame source and reference model
    // ------------------------------------------------------------------------
    function automatic void push_word(input link_word_t w, input chn_type_e chn,
                                      input int end_box);
        link_q.push_back(w);
        chn_q.push_back(chn);
        end_box_q.push_back(end_box);
    endfunction

    // kind 0 status, 1 data, 2 unknown type
    task automatic build_frame(input int n);
        chn_type_e   chn;
        int          pick;
        int          kind;
        int          len;
        int          i;
        int          dest;
        logic [2:0]  sbox;
        logic [1:0]  box;
        logic [3:0]  slot;
        logic [15:0] type_code;
        link_word_t  w;
        link_word_t  tag;

        case ($urandom_range(3, 0))
            0: chn = com1;
            1: chn = com2;
            2: chn = com3;
            default: chn = other;
        endcase
        pick = $urandom_range(9, 0);
        kind = (pick < 4) ? 0 : (pick < 8) ? 1 : 2;
        box  = 2'($urandom_range(3, 0));
        // a run of data frames all aimed at box 2
        if (n >= 100 && n < 140) begin
            kind = 1;
            box  = 2'd2;
        end
        slot = 4'($urandom_range(15, 0));
        len  = $urandom_range(20, 1);
        // COM1 counts boxes from one
        if (kind == 1) begin
            sbox = (chn == com1) ? 3'(box) + 3'd1 : 3'(box);
        end else begin
            sbox = 3'($urandom_range(7, 0));
        end
        case (kind)
            0: type_code = 16'(pkt_status);
            1: type_code = 16'(pkt_data);
            default: type_code = 16'($urandom_range(65535, 3));
        endcase

        // header, source, reserved, type, word 4
        push_word({2'b10, 16'($urandom)}, chn, -1);
        w = {2'b00, 16'($urandom)};
        w[SRC_BOX_LSB +: SRC_BOX_W] = sbox;
        w[SRC_SLOT_LSB +: SLOT_W]   = slot;
        push_word(w, chn, -1);
        push_word({2'b00, 16'($urandom)}, chn, -1);
        push_word({2'b00, type_code}, chn, -1);
        push_word({2'b00, 16'($urandom)}, chn, -1);

        dest = int'(sbox);
        for (i = 0; i < len; i++) begin
            w = {1'b0, (i == len - 1), 16'($urandom)};
            if (kind == 1) begin
                push_word(w, chn, (i == len - 1) ? int'(box) : -1);
                box_exp_q[box].push_back(w);
            end else begin
                push_word(w, chn, -1);
            end
            // status for boxes above 4 is dropped
            if (kind == 0 && dest < NUM_STA) begin
                if (i == 0) begin
                    tag = '0;
                    tag[SOP_BIT] = 1'b1;
                    tag[EOP_BIT] = w[EOP_BIT];
                    tag[SLOT_W +: SRC_BOX_W] = sbox;
                    tag[SLOT_W-1:0] = slot;
                    sta_exp_q[dest].push_back(tag);
                end else begin
                    sta_exp_q[dest].push_back(w);
                end
            end
        end
        // only COM1 uses the slot regions
        if (kind == 1) begin
            slot_exp_q[box].push_back((chn == com1) ? slot : SLOT_W'(0));
        end
    endtask

    function automatic bit all_drained();
        bit done;
        int i;

        done = (link_q.size() == 0) && !read_busy;
        for (i = 0; i < NUM_STA; i++) begin
            if (sta_exp_q[i].size() != 0) done = 1'b0;
        end
        for (i = 0; i < NUM_BOXES; i++) begin
            if (box_exp_q[i].size() != 0) done = 1'b0;
        end
        return done;
    endfunction

    // ------------------------------------------------------------------------
    // link FIFO model that answers a request one cycle later
    // ------------------------------------------------------------------------
    task automatic feed_link();
        logic       req;
        link_word_t w;
        chn_type_e  chn;
        int         eb;
        int         b;

        req = 1'b0;
        forever begin
            @(posedge clk_100m);
            #1;
            // empty flag must have dropped two cycles after the end word
            for (b = 0; b < NUM_BOXES; b++) begin
                if (fall_cnt[b] > 0) begin
                    fall_cnt[b] = fall_cnt[b] - 1;
                    if (fall_cnt[b] == 0) begin
                        check_value("rd_dmm_empty bit", 32'(rd_dmm_empty[b]), 32'd0);
                    end
                end
            end
            if (req) begin
                assert (link_q.size() > 0) else
                    stop_run("link read request accepted with no word left in the FIFO");
                w   = link_q.pop_front();
                chn = chn_q.pop_front();
                eb  = end_box_q.pop_front();
                if (w[SOP_BIT]) chn_type = chn;
                if (eb >= 0) fall_cnt[eb] = 2;
                slink_dval = 1'b1;
                slink_data = w;
            end else begin
                // junk on the bus while not valid
                slink_dval = 1'b0;
                slink_data = 18'($urandom);
            end
            // occasional stall
            slink_empty = (link_q.size() == 0) || ($urandom_range(7, 0) == 0);
            @(negedge clk_100m);
            // no request into an empty link FIFO
            if (slink_empty) begin
                check_value("slink_rdreq", 32'(slink_rdreq), 32'd0);
            end
            req = slink_rdreq;
        end
    endtask

    // ------------------------------------------------------------------------
    // slow reader draining one non-empty box region at a time
    // ------------------------------------------------------------------------
    task automatic read_boxes();
        int                found;
        int                start;
        int                i;
        int                n;
        int                k;
        logic [SLOT_W-1:0] slot;
        link_word_t        exp_words[$];

        forever begin
            repeat ($urandom_range(30, 0) + 1) begin
                @(posedge clk_100m);
                #1;
            end
            found = -1;
            while (found < 0) begin
                start = $urandom_range(3, 0);
                for (i = 0; i < NUM_BOXES; i++) begin
                    if (found < 0 && !rd_dmm_empty[(start + i) % NUM_BOXES]) begin
                        found = (start + i) % NUM_BOXES;
                    end
                end
                if (found < 0) begin
                    @(posedge clk_100m);
                    #1;
                end
            end
            read_busy = 1'b1;
            assert (box_exp_q[found].size() > 0) else
                stop_run($sformatf("box %0d holds a frame that was never sent to it", found));
            slot = slot_exp_q[found].pop_front();
            exp_words.delete();
            do begin
                exp_words.push_back(box_exp_q[found].pop_front());
            end while (!exp_words[$][EOP_BIT]);
            n = exp_words.size();

            // back to back reads with each return two cycles later
            for (k = 0; k < n + 2; k++) begin
                if (k >= 2) begin
                    check_value("rd_dval", 32'(rd_dval), 32'd1);
                    check_value("rd_data", 32'(rd_data), 32'(exp_words[k - 2]));
                end
                rd_sel  = (k < n);
                rd_port = {1'b0, BOX_W'(found), slot};
                rd_addr = OFS_W'(k);
                @(posedge clk_100m);
                #1;
            end
            // end word came back last cycle
            check_value("rd_dmm_empty bit", 32'(rd_dmm_empty[found]), 32'd1);
            read_busy = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // output monitors sampled mid cycle
    // ------------------------------------------------------------------------
    task automatic check_status();
        int d;

        assert ($onehot0(sta_dval)) else
            stop_run($sformatf("FAIL sta_dval: 0x%0h has more than one bit set", sta_dval));
        for (d = 0; d < NUM_STA; d++) begin
            if (sta_dval[d]) begin
                assert (sta_exp_q[d].size() > 0) else
                    stop_run($sformatf("unexpected status word on destination %0d", d));
                check_value("sta_data", 32'(sta_data), 32'(sta_exp_q[d].pop_front()));
            end
        end
    endtask

    always @(negedge clk_100m) begin
        if (rst_100m) begin
            check_status();
            // rd_dval is rd_sel two cycles late
            check_value("rd_dval", 32'(rd_dval), 32'(sel_hist[1]));
        end
        sel_hist = {sel_hist[0], rd_sel};
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int n;

        void'($urandom(54256));
        rst_100m    = 1'b0;
        chn_type    = other;
        slink_empty = 1'b1;
        slink_dval  = 1'b0;
        slink_data  = '0;
        rd_sel      = 1'b0;
        rd_port     = '0;
        rd_addr     = '0;
        for (n = 0; n < NUM_BOXES; n++) fall_cnt[n] = 0;
        for (n = 0; n < NUM_FRAMES; n++) build_frame(n);

        repeat (16) @(posedge clk_100m);
        #1;
        rst_100m = 1'b1;
        check_value("rd_dmm_empty", 32'(rd_dmm_empty), 32'hf);
        check_value("sta_dval", 32'(sta_dval), 32'h0);
        check_value("rd_dval", 32'(rd_dval), 32'h0);
        // request follows the link FIFO level out of reset
        slink_empty = 1'b0;
        #1;
        check_value("slink_rdreq", 32'(slink_rdreq), 32'h1);
        slink_empty = 1'b1;

        fork
            feed_link();
            read_boxes();
        join_none

        while (!all_drained()) @(posedge clk_100m);
        // output pipeline depth of the last link word
        repeat (3) @(posedge clk_100m);
        #1;
        check_value("rd_dmm_empty", 32'(rd_dmm_empty), 32'hf);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* mmrx/mmrx_top.sv */
`timescale 1ns/1ps
// receive memory manager top
// parses link frames, routes status frames and buffers data frames per box
module mmrx_top #(
    parameter int SLOT_WORDS = 64
) (
    input  logic                                clk_100m,
    input  logic                                rst_100m,
    input  mmrx_pkg::chn_type_e                 chn_type,
    // link FIFO side
    input  logic                                slink_empty,
    input  logic                                slink_dval,
    input  mmrx_pkg::link_word_t                slink_data,
    output logic                                slink_rdreq,
    // memory read-back side
    input  logic                                rd_sel,
    input  logic [mmrx_pkg::RD_PORT_W-1:0]      rd_port,
    input  logic [$clog2(SLOT_WORDS)-1:0]       rd_addr,
    output logic                                rd_dval,
    output mmrx_pkg::link_word_t                rd_data,
    output logic [mmrx_pkg::NUM_BOXES-1:0]      rd_dmm_empty,
    // status frame outputs, bit 0 is the main processor
    output logic [mmrx_pkg::NUM_STA-1:0]        sta_dval,
    output mmrx_pkg::link_word_t                sta_data
);
    import mmrx_pkg::*;

    localparam int AW = SLOT_W + $clog2(SLOT_WORDS);

    // parsed header fields
    logic [IDX_W-1:0]     word_idx;
    pkt_type_e            pkt_type;
    logic [SRC_BOX_W-1:0] src_box;
    logic [SLOT_W-1:0]    src_slot;
    logic [BOX_W-1:0]     box_num;

    // buffer write port
    logic                 wr_en;
    logic [BOX_W-1:0]     wr_box;
    logic [AW-1:0]        wr_addr;
    link_word_t           wr_data;

    frame_parser u_parser (
        .clk_100m    (clk_100m),
        .rst_100m    (rst_100m),
        .chn_type    (chn_type),
        .slink_empty (slink_empty),
        .slink_dval  (slink_dval),
        .slink_data  (slink_data),
        .box_empty   (rd_dmm_empty),
        .slink_rdreq (slink_rdreq),
        .word_idx    (word_idx),
        .pkt_type    (pkt_type),
        .src_box     (src_box),
        .src_slot    (src_slot),
        .box_num     (box_num)
    );

    write_ctrl #(
        .SLOT_WORDS (SLOT_WORDS)
    ) u_write (
        .clk_100m   (clk_100m),
        .rst_100m   (rst_100m),
        .slink_dval (slink_dval),
        .slink_data (slink_data),
        .word_idx   (word_idx),
        .pkt_type   (pkt_type),
        .box_num    (box_num),
        .src_slot   (src_slot),
        .chn_type   (chn_type),
        .wr_en      (wr_en),
        .wr_box     (wr_box),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    status_router u_status (
        .clk_100m   (clk_100m),
        .rst_100m   (rst_100m),
        .slink_dval (slink_dval),
        .slink_data (slink_data),
        .word_idx   (word_idx),
        .pkt_type   (pkt_type),
        .src_box    (src_box),
        .src_slot   (src_slot),
        .sta_dval   (sta_dval),
        .sta_data   (sta_data)
    );

    // empty flags go out as rd_dmm_empty and back to the parser
    buffer_array #(
        .SLOT_WORDS (SLOT_WORDS)
    ) u_buffers (
        .clk_100m  (clk_100m),
        .rst_100m  (rst_100m),
        .wr_en     (wr_en),
        .wr_box    (wr_box),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_sel    (rd_sel),
        .rd_port   (rd_port),
        .rd_addr   (rd_addr),
        .rd_dval   (rd_dval),
        .rd_data   (rd_data),
        .box_empty (rd_dmm_empty)
    );

endmodule

/* mmrx/write_ctrl.sv */
`timescale 1ns/1ps
// data frame writer
// writes payload words of data frames into the target box buffer
module write_ctrl #(
    parameter int SLOT_WORDS = 64
) (
    input  logic                                         clk_100m,
    input  logic                                         rst_100m,
    input  logic                                         slink_dval,
    input  mmrx_pkg::link_word_t                         slink_data,
    input  logic [mmrx_pkg::IDX_W-1:0]                   word_idx,
    input  mmrx_pkg::pkt_type_e                          pkt_type,
    input  logic [mmrx_pkg::BOX_W-1:0]                   box_num,
    input  logic [mmrx_pkg::SLOT_W-1:0]                  src_slot,
    input  mmrx_pkg::chn_type_e                          chn_type,
    output logic                                         wr_en,
    output logic [mmrx_pkg::BOX_W-1:0]                   wr_box,
    output logic [mmrx_pkg::SLOT_W+$clog2(SLOT_WORDS)-1:0] wr_addr,
    output mmrx_pkg::link_word_t                         wr_data
);
    import mmrx_pkg::*;

    localparam int OFS_W = $clog2(SLOT_WORDS);

    logic              first;
    logic              active;
    logic              wr_flag;
    logic [SLOT_W-1:0] base_slot;

    // first payload word of a data frame
    assign first  = slink_dval && !slink_data[SOP_BIT]
                 && (word_idx == IDX_W'(PAYLOAD_IDX)) && (pkt_type == pkt_data);
    assign active = first || (slink_dval && wr_flag);

    // only COM1 spreads frames over slot regions
    assign base_slot = (chn_type == com1) ? src_slot : '0;

    // stays clear on a one-word payload
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            wr_flag <= 1'b0;
        end else if (active && slink_data[EOP_BIT]) begin
            wr_flag <= 1'b0;
        end else if (first) begin
            wr_flag <= 1'b1;
        end
    end

    // write issued the cycle after the word arrives
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else begin
            wr_en <= active;
            if (first) begin
                wr_addr <= {base_slot, OFS_W'(0)};
            end else if (active) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        wr_box  <= box_num;
        wr_data <= slink_data;
    end

endmodule

/* mmrx/status_router.sv */
`timescale 1ns/1ps
// status frame router
// tags the first payload word with box and slot and forwards the frame
// to the status output of its source box
module status_router (
    input  logic                             clk_100m,
    input  logic                             rst_100m,
    input  logic                             slink_dval,
    input  mmrx_pkg::link_word_t             slink_data,
    input  logic [mmrx_pkg::IDX_W-1:0]       word_idx,
    input  mmrx_pkg::pkt_type_e              pkt_type,
    input  logic [mmrx_pkg::SRC_BOX_W-1:0]   src_box,
    input  logic [mmrx_pkg::SLOT_W-1:0]      src_slot,
    output logic [mmrx_pkg::NUM_STA-1:0]     sta_dval,
    output mmrx_pkg::link_word_t             sta_data
);
    import mmrx_pkg::*;

    logic       to_sta;
    logic       first;
    logic       sta_flag;
    logic       s1_vld;
    link_word_t s1_data;

    // status frame from a known destination, box 0 is the main processor
    assign to_sta = (pkt_type == pkt_status) && (src_box <= SRC_BOX_W'(NUM_STA - 1));
    assign first  = slink_dval && !slink_data[SOP_BIT]
                 && (word_idx == IDX_W'(PAYLOAD_IDX)) && to_sta;

    // open from the tag word up to the end word
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            sta_flag <= 1'b0;
        end else if (slink_dval && slink_data[EOP_BIT]) begin
            sta_flag <= 1'b0;
        end else if (first) begin
            sta_flag <= 1'b1;
        end
    end

    // stage 1, tag replaces the first payload word
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= slink_dval && (first || sta_flag);
        end
    end

    always_ff @(posedge clk_100m) begin
        if (first) begin
            s1_data <= {1'b1, slink_data[EOP_BIT], 8'h00, 1'b0, src_box, src_slot};
        end else begin
            s1_data <= slink_data;
        end
    end

    // stage 2, one-hot destination
    // src_box holds until word 1 of the next frame, after the last word leaves
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            sta_dval <= '0;
        end else begin
            sta_dval <= s1_vld ? (NUM_STA'(1) << src_box) : '0;
        end
    end

    always_ff @(posedge clk_100m) begin
        sta_data <= s1_data;
    end

endmodule

/* mmrx/frame_parser.sv */
`timescale 1ns/1ps
// frame parser
// counts words per frame, captures source address and packet type,
// and holds off link reads while a data frame waits for its box
module frame_parser (
    input  logic                             clk_100m,
    input  logic                             rst_100m,
    input  mmrx_pkg::chn_type_e              chn_type,
    input  logic                             slink_empty,
    input  logic                             slink_dval,
    input  mmrx_pkg::link_word_t             slink_data,
    input  logic [mmrx_pkg::NUM_BOXES-1:0]   box_empty,
    output logic                             slink_rdreq,
    output logic [mmrx_pkg::IDX_W-1:0]       word_idx,
    output mmrx_pkg::pkt_type_e              pkt_type,
    output logic [mmrx_pkg::SRC_BOX_W-1:0]   src_box,
    output logic [mmrx_pkg::SLOT_W-1:0]      src_slot,
    output logic [mmrx_pkg::BOX_W-1:0]       box_num
);
    import mmrx_pkg::*;

    chn_type_e            chn_type_q;
    logic                 sop_in;
    logic                 body_in;
    logic                 at_type;
    logic                 data_busy;
    logic                 hold;
    logic [SRC_BOX_W-1:0] box_adj;

    assign sop_in  = slink_dval && slink_data[SOP_BIT];
    // non-sop words, word_idx is then the index of the incoming word
    assign body_in = slink_dval && !slink_data[SOP_BIT];
    assign at_type = body_in && (word_idx == IDX_W'(TYPE_WORD_IDX));

    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            chn_type_q <= other;
        end else begin
            chn_type_q <= chn_type;
        end
    end

    // ------------------------------------------------------------------------
    // word counter and header capture
    // ------------------------------------------------------------------------
    // out of reset saturated so nothing decodes before the first sop
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            word_idx <= '1;
        end else if (sop_in) begin
            word_idx <= IDX_W'(1);
        end else if (slink_dval && (word_idx != '1)) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            src_box  <= '0;
            src_slot <= '0;
            pkt_type <= pkt_type_e'('0);
        end else begin
            if (body_in && (word_idx == IDX_W'(SRC_WORD_IDX))) begin
                src_box  <= slink_data[SRC_BOX_LSB +: SRC_BOX_W];
                src_slot <= slink_data[SRC_SLOT_LSB +: SLOT_W];
            end
            // unknown codes are kept as is and match neither type
            if (at_type) begin
                pkt_type <= pkt_type_e'(slink_data[15:0]);
            end
        end
    end

    // COM1 numbers its boxes from one
    assign box_adj = (chn_type_q == com1) ? src_box - 1'b1 : src_box;
    assign box_num = box_adj[BOX_W-1:0];

    // ------------------------------------------------------------------------
    // intake hold-off
    // ------------------------------------------------------------------------
    // data frame for a box that still holds an unread frame
    assign data_busy = at_type && (slink_data[15:0] == pkt_data) && !box_empty[box_num];

    // word 4 is already requested when hold rises, payload is not
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            hold <= 1'b0;
        end else if (data_busy) begin
            hold <= 1'b1;
        end else if (hold && box_empty[box_num]) begin
            hold <= 1'b0;
        end
    end

    assign slink_rdreq = !slink_empty && !hold;

endmodule

/* buffer/buffer_array.sv */
`timescale 1ns/1ps
// box buffer array
// four box memories with write/read decode and the read-return select
module buffer_array #(
    parameter int SLOT_WORDS = 64
) (
    input  logic                                         clk_100m,
    input  logic                                         rst_100m,
    input  logic                                         wr_en,
    input  logic [mmrx_pkg::BOX_W-1:0]                   wr_box,
    input  logic [mmrx_pkg::SLOT_W+$clog2(SLOT_WORDS)-1:0] wr_addr,
    input  mmrx_pkg::link_word_t                         wr_data,
    input  logic                                         rd_sel,
    input  logic [mmrx_pkg::RD_PORT_W-1:0]               rd_port,
    input  logic [$clog2(SLOT_WORDS)-1:0]                rd_addr,
    output logic                                         rd_dval,
    output mmrx_pkg::link_word_t                         rd_data,
    output logic [mmrx_pkg::NUM_BOXES-1:0]               box_empty
);
    import mmrx_pkg::*;

    localparam int AW = SLOT_W + $clog2(SLOT_WORDS);

    logic [BOX_W-1:0] rd_box;
    logic [BOX_W-1:0] rd_box_q;
    logic [AW-1:0]    rd_word_addr;
    logic             rd_vld_q;
    link_word_t       rd_word [NUM_BOXES];

    // box in 5:4, slot region in 3:0
    assign rd_box       = rd_port[SLOT_W +: BOX_W];
    assign rd_word_addr = {rd_port[SLOT_W-1:0], rd_addr};

    for (genvar i = 0; i < NUM_BOXES; i++) begin : g_box
        box_buffer #(
            .SLOT_WORDS (SLOT_WORDS)
        ) u_box (
            .clk_100m (clk_100m),
            .rst_100m (rst_100m),
            .wr_en    (wr_en && (wr_box == BOX_W'(i))),
            .wr_addr  (wr_addr),
            .wr_data  (wr_data),
            .rd_en    (rd_sel && (rd_box == BOX_W'(i))),
            .rd_addr  (rd_word_addr),
            .rd_word  (rd_word[i]),
            .empty    (box_empty[i])
        );
    end

    // cycle 1 RAM read, cycle 2 return select
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            rd_vld_q <= 1'b0;
            rd_dval  <= 1'b0;
        end else begin
            rd_vld_q <= rd_sel;
            rd_dval  <= rd_vld_q;
        end
    end

    always_ff @(posedge clk_100m) begin
        rd_box_q <= rd_box;
        rd_data  <= rd_word[rd_box_q];
    end

endmodule

/* buffer/box_buffer.sv */
`timescale 1ns/1ps
// expansion box frame memory
// 16 slot regions with registered read and an empty flag per box
module box_buffer #(
    parameter int SLOT_WORDS = 64
) (
    input  logic                                         clk_100m,
    input  logic                                         rst_100m,
    input  logic                                         wr_en,
    input  logic [mmrx_pkg::SLOT_W+$clog2(SLOT_WORDS)-1:0] wr_addr,
    input  mmrx_pkg::link_word_t                         wr_data,
    input  logic                                         rd_en,
    input  logic [mmrx_pkg::SLOT_W+$clog2(SLOT_WORDS)-1:0] rd_addr,
    output mmrx_pkg::link_word_t                         rd_word,
    output logic                                         empty
);
    import mmrx_pkg::*;

    localparam int DEPTH = (1 << SLOT_W) * SLOT_WORDS;

    link_word_t mem [DEPTH];
    logic       rd_vld_q;
    logic       end_seen;

    // simple dual port RAM
    always_ff @(posedge clk_100m) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

    // end word leaves the array one cycle after rd_word
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            rd_vld_q <= 1'b0;
            end_seen <= 1'b0;
        end else begin
            rd_vld_q <= rd_en;
            end_seen <= rd_vld_q && rd_word[EOP_BIT];
        end
    end

    // a completed write wins over a read-back of the old frame
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            empty <= 1'b1;
        end else if (wr_en && wr_data[EOP_BIT]) begin
            empty <= 1'b0;
        end else if (end_seen) begin
            empty <= 1'b1;
        end
    end

endmodule

/* common/mmrx_pkg.sv */
// mmrx shared definitions
// link word format, source address fields, frame offsets and encodings
package mmrx_pkg;

    // one link word, frame marks in the two top bits
    typedef logic [17:0] link_word_t;

    localparam int SOP_BIT = 17;
    localparam int EOP_BIT = 16;

    // source address word layout
    localparam int SRC_BOX_LSB  = 7;
    localparam int SRC_BOX_W    = 3;
    localparam int SRC_SLOT_LSB = 2;
    localparam int SLOT_W       = 4;

    // word positions inside a frame
    localparam int SRC_WORD_IDX  = 1;
    localparam int TYPE_WORD_IDX = 3;
    localparam int PAYLOAD_IDX   = 5;
    // saturating counter, sticks at all ones past the header
    localparam int IDX_W         = 3;

    // buffer and status destination counts
    localparam int NUM_BOXES = 4;
    localparam int NUM_STA   = 5;
    localparam int BOX_W     = 2;
    // read port: box in 5:4, slot in 3:0
    localparam int RD_PORT_W = 7;

    // channel type of the link
    typedef enum logic [4:0] {
        other = 5'd0,
        com1  = 5'd1,
        com2  = 5'd2,
        com3  = 5'd3
    } chn_type_e;

    // packet type word, anything else is an unknown frame
    typedef enum logic [15:0] {
        pkt_status = 16'h0001,
        pkt_data   = 16'h0002
    } pkt_type_e;

endpackage
